// File: flist.f
+incdir+src
src/spm_pkg.sv
src/spm_ifs.sv
src/store_align.sv
src/sram_sdp_plain.sv
src/load_extract.sv
src/spm_top.sv
bench/spm_properties.sv
bench/spm_tb.sv

// File: Makefile
# Verilator build and run of the scratchpad testbench
# pass or fail comes from the pass line in the simulator output

SIM   ?= verilator
TOP   ?= spm_tb
FLIST ?= flist.f
OBJ   ?= obj_dir
FLAGS ?= --binary --timing --assert -j 0

SRCS  := $(filter-out +%,$(shell cat $(FLIST)))
HDRS  := $(wildcard src/*.svh)
BIN   := $(OBJ)/V$(TOP)
PASS  := Simulation completed successfully

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS)"

clean:
	rm -rf $(OBJ)

// File: bench/spm_tb.sv
// self-checking testbench for the scratchpad, single clock clk_a
// model starts empty, fill_words must run before any other test
`include "spm_consts.svh"

module spm_tb
   import spm_pkg::*;
();

   typedef logic [`SPM_AW-1:0] addr_t;

   localparam int N_FILL      = `SPM_DEPTH;
   localparam int N_MERGE     = 200;
   localparam int N_SIGN      = 200;
   localparam int N_MIS       = 50;
   localparam int N_RAND      = 2000;
   localparam int N_OPS       = 2*N_FILL + 2*N_MERGE + N_SIGN + 3*N_MIS + N_RAND;
   localparam int CYCLE_LIMIT = 4*N_OPS + 100;
   localparam logic [31:0] SEED = 32'h0cdd_27c9;

   logic          clk_a;
   logic          rst_n;
   logic          st_valid;
   addr_t         st_addr;
   access_size_e  st_size;
   word_t         st_data;
   logic          ld_valid;
   addr_t         ld_addr;
   access_size_e  ld_size;
   logic          ld_signed;
   logic          ld_rdy;
   word_t         ld_data;
   logic          st_misaligned;
   logic          ld_misaligned;

   logic [7:0]    mem_model [1 << `SPM_AW];   // byte model, little endian lanes
   word_t         exp_q [$];                  // expected load results
   string         name_q [$];                 // test name per pending load
   string         test_name;
   logic [31:0]   lcg_state;
   word_t         cmp_exp;
   string         cmp_name;

   int val_errs     = 0;   // compare process
   int other_errs   = 0;
   int cnt_errs     = 0;   // count checks in main flow
   int rdy_count    = 0;
   int st_mis_count = 0;
   int ld_mis_count = 0;
   int exp_rdy      = 0;
   int exp_st_mis   = 0;
   int exp_ld_mis   = 0;
   int cycle_count  = 0;

   spm_top u_spm_top (.*);

   bind spm_top spm_properties u_spm_properties (
      .clk_a         (clk_a),
      .rst_n         (rst_n),
      .st_valid      (st_valid),
      .st_addr       (st_addr),
      .st_size       (st_size),
      .ld_valid      (ld_valid),
      .ld_addr       (ld_addr),
      .ld_size       (ld_size),
      .ld_rdy        (ld_rdy),
      .st_misaligned (st_misaligned),
      .ld_misaligned (ld_misaligned),
      .we            (wr_bus.we),
      .sel           (wr_bus.sel),
      .oe            (rd_bus.oe)
   );

   always #4 clk_a = ~clk_a;   // period 8

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic access_size_e size_from(logic [1:0] c);
      case (c)
         2'd0:    return size_byte;
         2'd1:    return size_half;
         default: return size_word;   // word twice as likely
      endcase
   endfunction

   function automatic logic misaligned(addr_t a, access_size_e s);
      if (s == size_half) return a[0];
      if (s == size_word) return a[1:0] != 2'b00;
      return 1'b0;
   endfunction

   function automatic addr_t align_addr(addr_t a, access_size_e s);
      if (s == size_half) return a & ~addr_t'(1);
      if (s == size_word) return a & ~addr_t'(3);
      return a;
   endfunction

   // expected load value from the byte model
   function automatic word_t ref_load(addr_t a, access_size_e s, logic sgn);
      logic [7:0]  b;
      logic [15:0] h;
      case (s)
         size_byte: begin
            b = mem_model[a];
            return {{(`SPM_DW-8){sgn & b[7]}}, b};
         end
         size_half: begin
            h = {mem_model[a | addr_t'(1)], mem_model[a]};
            return {{(`SPM_DW-16){sgn & h[15]}}, h};
         end
         default: return {mem_model[a | addr_t'(3)], mem_model[a | addr_t'(2)],
                          mem_model[a | addr_t'(1)], mem_model[a]};
      endcase
   endfunction

   function automatic void apply_store(addr_t a, access_size_e s, word_t d);
      mem_model[a] = d[7:0];
      if (s != size_byte) mem_model[a | addr_t'(1)] = d[15:8];
      if (s == size_word) begin
         mem_model[a | addr_t'(2)] = d[23:16];
         mem_model[a | addr_t'(3)] = d[31:24];
      end
   endfunction

   // one clock of stimulus, model and queue updated at issue
   task automatic cycle_op(input logic do_st, input addr_t sa, input access_size_e ss,
                           input word_t sd, input logic do_ld, input addr_t la,
                           input access_size_e ls, input logic lsg);
      @(posedge clk_a);
      st_valid  <= do_st;
      st_addr   <= sa;
      st_size   <= ss;
      st_data   <= sd;
      ld_valid  <= do_ld;
      ld_addr   <= la;
      ld_size   <= ls;
      ld_signed <= lsg;
      // load first, a same-cycle store is not visible yet
      if (do_ld && misaligned(la, ls)) exp_ld_mis++;
      if (do_ld && !misaligned(la, ls)) begin
         exp_q.push_back(ref_load(la, ls, lsg));
         name_q.push_back(test_name);
         exp_rdy++;
      end
      if (do_st && misaligned(sa, ss)) exp_st_mis++;
      if (do_st && !misaligned(sa, ss)) apply_store(sa, ss, sd);
   endtask

   task automatic store(input addr_t a, input access_size_e s, input word_t d);
      cycle_op(1'b1, a, s, d, 1'b0, '0, size_byte, 1'b0);
   endtask

   task automatic load(input addr_t a, input access_size_e s, input logic sgn);
      cycle_op(1'b0, '0, size_byte, '0, 1'b1, a, s, sgn);
   endtask

   task automatic idle(input int n);
      repeat (n) cycle_op(1'b0, '0, size_byte, '0, 1'b0, '0, size_byte, 1'b0);
   endtask

   // cumulative counts, pipeline drained first
   task automatic check_counts();
      idle(4);
      if (rdy_count != exp_rdy) begin
         $display("ERR %s ld_rdy count expected %0d actual %0d",
                  test_name, exp_rdy, rdy_count);
         cnt_errs++;
      end
      if (st_mis_count != exp_st_mis) begin
         $display("ERR %s st_misaligned count expected %0d actual %0d",
                  test_name, exp_st_mis, st_mis_count);
         cnt_errs++;
      end
      if (ld_mis_count != exp_ld_mis) begin
         $display("ERR %s ld_misaligned count expected %0d actual %0d",
                  test_name, exp_ld_mis, ld_mis_count);
         cnt_errs++;
      end
   endtask

   task automatic run_fill_words();
      test_name = "fill_words";
      for (int i = 0; i < N_FILL; i++) store(addr_t'(i * 4), size_word, lcg_next());
      idle(2);
      for (int i = 0; i < N_FILL; i++) load(addr_t'(i * 4), size_word, 1'b0);
      check_counts();
   endtask

   task automatic run_byte_half_merge();
      logic [31:0]   r;
      access_size_e  s;
      addr_t         hit [N_MERGE];   // touched addresses
      test_name = "byte_half_merge";
      for (int i = 0; i < N_MERGE; i++) begin
         r = lcg_next();
         s = r[20] ? size_half : size_byte;
         hit[i] = align_addr(addr_t'(r >> 16), s);
         store(hit[i], s, lcg_next());
      end
      idle(2);
      for (int i = 0; i < N_MERGE; i++) load(align_addr(hit[i], size_word), size_word, 1'b0);
      check_counts();
   endtask

   task automatic run_sign_extend();
      logic [31:0]   r;
      access_size_e  s;
      test_name = "sign_extend";
      for (int i = 0; i < N_SIGN; i++) begin
         r = lcg_next();
         s = r[4] ? size_half : size_byte;
         load(align_addr(addr_t'(r >> 16), s), s, r[5]);   // signed and unsigned mixed
      end
      check_counts();
   endtask

   task automatic run_misaligned();
      logic [31:0]   r;
      access_size_e  s;
      addr_t         a;
      addr_t         bad [N_MIS];
      test_name = "misaligned";
      for (int i = 0; i < N_MIS; i++) begin
         r = lcg_next();
         s = r[3] ? size_half : size_word;
         a = addr_t'(r >> 16) | addr_t'(1);   // odd, wrong for half and word
         bad[i] = a;
         store(a, s, lcg_next());
      end
      idle(2);
      for (int i = 0; i < N_MIS; i++) load(align_addr(bad[i], size_word), size_word, 1'b0);
      for (int i = 0; i < N_MIS; i++) begin
         r = lcg_next();
         s = r[3] ? size_half : size_word;
         load(addr_t'(r >> 16) | addr_t'(1), s, r[4]);   // no ld_rdy expected
      end
      check_counts();
   endtask

   task automatic run_back_to_back();
      logic [31:0]              r;
      logic                     do_st;
      logic                     do_ld;
      access_size_e             ss;
      access_size_e             ls;
      addr_t                    sa;
      addr_t                    la;
      logic                     prev_st;
      logic [`SPM_WORD_AW-1:0]  prev_word;
      test_name = "back_to_back";
      prev_st   = 1'b0;
      prev_word = '0;
      for (int i = 0; i < N_RAND; i++) begin
         r     = lcg_next();
         do_st = r[16];
         do_ld = r[17];
         ss    = size_from(r[19:18]);
         ls    = size_from(r[21:20]);
         sa    = addr_t'(lcg_next() >> 20);
         la    = addr_t'(lcg_next() >> 20);
         if (r[23]) sa = align_addr(sa, ss);   // mostly aligned, some misaligned
         if (r[24]) la = align_addr(la, ls);
         // word written last cycle is not yet in the RAM
         if (prev_st && la[`SPM_AW-1:2] == prev_word) la = la ^ addr_t'(4);
         cycle_op(do_st, sa, ss, lcg_next(), do_ld, la, ls, r[22]);
         prev_st   = do_st && !misaligned(sa, ss);
         prev_word = sa[`SPM_AW-1:2];
      end
      check_counts();
   endtask

   // compare and count, sampled away from the active edge
   always @(negedge clk_a) begin
      if (rst_n) begin
         if (st_misaligned) st_mis_count++;
         if (ld_misaligned) ld_mis_count++;
         if (ld_rdy) begin
            rdy_count++;
            if (exp_q.size() == 0) begin
               $display("ld_rdy came with no load outstanding");
               other_errs++;
            end else begin
               cmp_exp  = exp_q.pop_front();
               cmp_name = name_q.pop_front();
               if (ld_data !== cmp_exp) begin
                  $display("ERR %s expected %08h actual %08h", cmp_name, cmp_exp, ld_data);
                  val_errs++;
               end
            end
         end
      end
   end

   always @(posedge clk_a) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout, run still busy after %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin
      lcg_state = SEED;
      clk_a     = 1'b0;
      rst_n     = 1'b0;
      st_valid  = 1'b0;
      st_addr   = '0;
      st_size   = size_byte;
      st_data   = '0;
      ld_valid  = 1'b0;
      ld_addr   = '0;
      ld_size   = size_byte;
      ld_signed = 1'b0;
      repeat (16) @(posedge clk_a);
      rst_n <= 1'b1;
      run_fill_words();
      run_byte_half_merge();
      run_sign_extend();
      run_misaligned();
      run_back_to_back();
      $display("errors: value %0d, count %0d, other %0d", val_errs, cnt_errs, other_errs);
      if (val_errs + cnt_errs + other_errs == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: bench/spm_properties.sv
// timing and write gating checks on the scratchpad top level
// bound into spm_top with RAM strobes taken from the interface instances
`include "spm_consts.svh"

module spm_properties
   import spm_pkg::*;
(
   input  logic                clk_a,
   input  logic                rst_n,
   input  logic                st_valid,
   input  logic [`SPM_AW-1:0]  st_addr,
   input  access_size_e        st_size,
   input  logic                ld_valid,
   input  logic [`SPM_AW-1:0]  ld_addr,
   input  access_size_e        ld_size,
   input  logic                ld_rdy,
   input  logic                st_misaligned,
   input  logic                ld_misaligned,
   input  logic                we,
   input  byte_sel_t           sel,
   input  logic                oe
);

   logic      st_bad;     // misaligned store request
   logic      ld_go;      // aligned load request
   int        st_bytes;   // bytes written by the store request
   byte_sel_t st_lanes;   // lanes covered by the store request

   assign st_bad = st_valid &&
                   ((st_size == size_half && st_addr[0]) ||
                    (st_size == size_word && st_addr[1:0] != 2'b00));
   assign ld_go  = ld_valid &&
                   !((ld_size == size_half && ld_addr[0]) ||
                     (ld_size == size_word && ld_addr[1:0] != 2'b00));

   assign st_bytes = (st_size == size_byte) ? 1 :
                     (st_size == size_half) ? 2 : `SPM_SW;

   // lane i is hit when it lies in [offset, offset + bytes)
   always_comb begin
      for (int i = 0; i < `SPM_SW; i++) begin
         st_lanes[i] = (i >= int'(st_addr[1:0])) &&
                       (i < int'(st_addr[1:0]) + st_bytes);
      end
   end

   // fixed two cycle load latency in both directions
   a_ld_latency: assert property (@(posedge clk_a) disable iff (!rst_n)
      ld_rdy == $past(ld_go, 2))
      else $error("ld_rdy not two cycles after an aligned load");

   a_no_bad_write: assert property (@(posedge clk_a) disable iff (!rst_n)
      $past(st_bad) |-> !we)   // dropped store
      else $error("write strobe after a misaligned store");

   a_sel_set: assert property (@(posedge clk_a) disable iff (!rst_n)
      we |-> sel != '0 && sel == $past(st_lanes))
      else $error("write strobe with wrong byte select");

   // everything quiet right after reset release
   a_reset_quiet: assert property (@(posedge clk_a)
      $rose(rst_n) |-> !ld_rdy && !st_misaligned && !ld_misaligned && !we && !oe)
      else $error("outputs or strobes active after reset");

endmodule

// File: src/spm_top.sv
// byte-addressable scratchpad, one store and one load port
// a load sees stores sampled two or more edges earlier
`include "spm_consts.svh"

module spm_top
   import spm_pkg::*;
(
   input  logic                clk_a,
   input  logic                rst_n,

   // store request
   input  logic                st_valid,
   input  logic [`SPM_AW-1:0]  st_addr,
   input  access_size_e        st_size,
   input  word_t               st_data,

   // load request
   input  logic                ld_valid,
   input  logic [`SPM_AW-1:0]  ld_addr,
   input  access_size_e        ld_size,
   input  logic                ld_signed,

   // results
   output logic                ld_rdy,
   output word_t               ld_data,
   output logic                st_misaligned,
   output logic                ld_misaligned
);

   mem_wr_if wr_bus ();   // store stage to RAM
   mem_rd_if rd_bus ();   // load stage to RAM and back

   store_align u_store_align (
      .clk_a         (clk_a),
      .rst_n         (rst_n),
      .st_valid      (st_valid),
      .st_addr       (st_addr),
      .st_size       (st_size),
      .st_data       (st_data),
      .st_misaligned (st_misaligned),
      .wr            (wr_bus.stage)
   );

   sram_sdp_plain u_sram (
      .clk_a (clk_a),
      .wr    (wr_bus.ram),
      .rd    (rd_bus.ram)
   );

   load_extract u_load_extract (
      .clk_a         (clk_a),
      .rst_n         (rst_n),
      .ld_valid      (ld_valid),
      .ld_addr       (ld_addr),
      .ld_size       (ld_size),
      .ld_signed     (ld_signed),
      .rd            (rd_bus.stage),
      .ld_rdy        (ld_rdy),
      .ld_data       (ld_data),
      .ld_misaligned (ld_misaligned)
   );

endmodule

// File: src/load_extract.sv
// load side: RAM read at the sampling edge, result one edge later
// fixed 2 cycle latency, no back-pressure on ld_rdy
`include "spm_consts.svh"

module load_extract
   import spm_pkg::*;
(
   input  logic                clk_a,
   input  logic                rst_n,
   input  logic                ld_valid,
   input  logic [`SPM_AW-1:0]  ld_addr,
   input  access_size_e        ld_size,
   input  logic                ld_signed,
   mem_rd_if.stage             rd,
   output logic                ld_rdy,
   output word_t               ld_data,
   output logic                ld_misaligned
);

   lane_off_t     off;
   logic          aligned;

   // side info travelling with the RAM read
   logic          s1_valid;
   lane_off_t     s1_off;
   access_size_e  s1_size;
   logic          s1_signed;

   word_t         shifted;     // addressed byte moved to lane 0
   word_t         ext;         // extended result

   assign off     = ld_addr[`SPM_AW-`SPM_WORD_AW-1:0];
   assign aligned = is_aligned(ld_size, off);

   // read issued straight from the request, RAM registers it
   assign rd.oe    = ld_valid & aligned;
   assign rd.raddr = ld_addr[`SPM_AW-1:`SPM_AW-`SPM_WORD_AW];

   // stage 1 control
   always_ff @(posedge clk_a) begin
      if (!rst_n) begin
         s1_valid      <= 1'b0;
         ld_misaligned <= 1'b0;
      end else begin
         s1_valid      <= ld_valid & aligned;
         ld_misaligned <= ld_valid & ~aligned;   // dropped, no ld_rdy later
      end
   end

   // stage 1 payload
   always_ff @(posedge clk_a) begin
      if (rd.oe) begin
         s1_off    <= off;
         s1_size   <= ld_size;
         s1_signed <= ld_signed;
      end
   end

   // shift down by offset, then mask and extend
   always_comb begin
      shifted = rd.dout >> {s1_off, 3'b000};
      case (s1_size)
         size_byte: ext = {{(`SPM_DW-8){s1_signed & shifted[7]}}, shifted[7:0]};
         size_half: ext = {{(`SPM_DW-16){s1_signed & shifted[15]}}, shifted[15:0]};
         default:   ext = shifted;                 // word, offset is zero
      endcase
   end

   // stage 2 result
   always_ff @(posedge clk_a) begin
      if (!rst_n) begin
         ld_rdy <= 1'b0;
      end else begin
         ld_rdy <= s1_valid;
      end
   end

   always_ff @(posedge clk_a) begin
      if (s1_valid) begin
         ld_data <= ext;   // held until next load
      end
   end

endmodule

// File: src/sram_sdp_plain.sv
// simple dual-port RAM in plain registers, single clock
// read during write to the same word returns the old word
// contents undefined after power-up, no reset or init
`include "spm_consts.svh"

module sram_sdp_plain
   import spm_pkg::*;
(
   input  logic    clk_a,
   mem_wr_if.ram   wr,
   mem_rd_if.ram   rd
);

   // word storage, indexed by word address
   word_t mem [`SPM_DEPTH];

   // write port
   // only lanes with sel set are touched
   always_ff @(posedge clk_a) begin
      if (wr.we) begin
         for (int i = 0; i < `SPM_SW; i++) begin
            if (wr.sel[i]) begin
               mem[wr.waddr][i*8 +: 8] <= wr.din[i*8 +: 8];
            end
         end
      end
   end

   // read port
   // dout keeps last word while oe is low
   always_ff @(posedge clk_a) begin
      if (rd.oe) begin
         rd.dout <= mem[rd.raddr];   // one cycle read latency
      end
   end

endmodule

// File: src/store_align.sv
// store side: alignment check, lane select and data replication
// one store per cycle, write reaches the RAM one edge after sampling
`include "spm_consts.svh"

module store_align
   import spm_pkg::*;
(
   input  logic                clk_a,
   input  logic                rst_n,
   input  logic                st_valid,
   input  logic [`SPM_AW-1:0]  st_addr,
   input  access_size_e        st_size,
   input  word_t               st_data,
   output logic                st_misaligned,
   mem_wr_if.stage             wr
);

   lane_off_t                off;        // byte offset in word
   logic [`SPM_WORD_AW-1:0]  word_addr;
   logic                     aligned;
   byte_sel_t                sel_nxt;
   word_t                    din_nxt;

   assign off       = st_addr[`SPM_AW-`SPM_WORD_AW-1:0];
   assign word_addr = st_addr[`SPM_AW-1:`SPM_AW-`SPM_WORD_AW];
   assign aligned   = is_aligned(st_size, off);

   // lane select and replicated data
   always_comb begin
      case (st_size)
         size_byte: begin
            sel_nxt = byte_sel_t'(1) << off;            // single lane
            din_nxt = {(`SPM_SW){st_data[7:0]}};        // byte in every lane
         end
         size_half: begin
            sel_nxt = byte_sel_t'(3) << off;            // off is 0 or 2 here
            din_nxt = {(`SPM_SW/2){st_data[15:0]}};
         end
         default: begin
            sel_nxt = '1;                               // whole word
            din_nxt = st_data;
         end
      endcase
   end

   // write strobe and error pulse
   always_ff @(posedge clk_a) begin
      if (!rst_n) begin
         wr.we         <= 1'b0;
         st_misaligned <= 1'b0;
      end else begin
         wr.we         <= st_valid & aligned;
         st_misaligned <= st_valid & ~aligned;   // one-cycle pulse, no write
      end
   end

   // write payload, only loaded for a real write
   always_ff @(posedge clk_a) begin
      if (st_valid && aligned) begin
         wr.waddr <= word_addr;
         wr.din   <= din_nxt;
         wr.sel   <= sel_nxt;
      end
   end

endmodule

// File: src/spm_ifs.sv
// RAM port bundles between the pipeline stages and the RAM
// no clock inside, all users sample on clk_a
`include "spm_consts.svh"

// write port, driven by the store stage
interface mem_wr_if
   import spm_pkg::*;
();
   logic                     we;     // write strobe
   logic [`SPM_WORD_AW-1:0]  waddr;  // word address
   word_t                    din;    // lane-replicated data
   byte_sel_t                sel;    // lanes to update

   modport stage (
      output we, waddr, din, sel
   );

   modport ram (
      input we, waddr, din, sel
   );
endinterface

// read port, address from the load stage, data back from the RAM
interface mem_rd_if
   import spm_pkg::*;
();
   logic                     oe;     // read strobe
   logic [`SPM_WORD_AW-1:0]  raddr;  // word address
   word_t                    dout;   // registered read data, held when oe low

   modport stage (
      output oe, raddr,
      input  dout
   );

   modport ram (
      input  oe, raddr,
      output dout
   );
endinterface

// File: src/spm_pkg.sv
// common types for the scratchpad stages and RAM
// alignment helper assumes 4 byte lanes per word
`include "spm_consts.svh"

package spm_pkg;

   // access width of a load or store
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } access_size_e;

   typedef logic [`SPM_SW-1:0] byte_sel_t;  // one bit per lane
   typedef logic [`SPM_DW-1:0] word_t;

   // byte offset inside a word
   typedef logic [`SPM_AW-`SPM_WORD_AW-1:0] lane_off_t;

   // natural alignment check, shared by load and store side
   function automatic logic is_aligned(access_size_e size, lane_off_t off);
      case (size)
         size_byte: return 1'b1;             // any byte is fine
         size_half: return ~off[0];          // even address
         default:   return off == '0;        // word, also the unused code
      endcase
   endfunction

endpackage

// File: src/spm_consts.svh
// sizing of the scratchpad, single clock domain
// data width must be a multiple of 8, lane count a power of two
`ifndef SPM_CONSTS_SVH
`define SPM_CONSTS_SVH

// byte address width
`define SPM_AW 12

// data word width
`define SPM_DW 32

// byte lanes per word
`define SPM_SW (`SPM_DW / 8)

// word address width, byte offset bits dropped
`define SPM_WORD_AW (`SPM_AW - 2)

// words held in the RAM, fills the whole word address space
`define SPM_DEPTH 1024

`endif
